// ==== Bender.yml ====
package:
  name: flash_scramble

sources:
  - hw/flash_scramble_pkg.sv
  - hw/scramble_key_regs.sv
  - hw/bank_arbiter.sv
  - hw/gf_mult_serial.sv
  - hw/spn_cipher.sv
  - hw/flash_scramble.sv
  - hw/flash_scramble_top.sv
  - target: test
    files:
      - dv/flash_scramble_tb.sv

// ==== dv/flash_scramble_tb.sv ====
/* Testbench for the flash scramble top level, acting as both flash banks.
   Reads commands and expected results from the stim file and checks each ack. */
`default_nettype none

module flash_scramble_tb;
  import flash_scramble_pkg::*;

  localparam int TimeoutCycles = 50;

  logic                                clk, rst_n;
  logic                                cfg_we;
  logic [CfgAddrW-1:0]                 cfg_addr;
  logic [DataWidth-1:0]                cfg_wdata;
  logic [NumBanks-1:0]                 calc_req, calc_ack, op_req, op_ack, op_type;
  logic [NumBanks-1:0][BankAddrW-1:0]  calc_addr;
  logic [NumBanks-1:0][DataWidth-1:0]  plain_in, scr_in;
  logic [DataWidth-1:0]                mask, plain_out, scr_out;
  logic [15:0]                         lfsr;
  int                                  n_pass, n_fail;

  flash_scramble_top flash_scramble_top_i (
    .clk_i            (clk),
    .rst_ni           (rst_n),
    .cfg_we_i         (cfg_we),
    .cfg_addr_i       (cfg_addr),
    .cfg_wdata_i      (cfg_wdata),
    .calc_req_i       (calc_req),
    .calc_addr_i      (calc_addr),
    .calc_ack_o       (calc_ack),
    .mask_o           (mask),
    .op_req_i         (op_req),
    .op_type_i        (op_type),
    .plain_data_i     (plain_in),
    .scrambled_data_i (scr_in),
    .op_ack_o         (op_ack),
    .plain_data_o     (plain_out),
    .scrambled_data_o (scr_out)
  );

  always #5 clk = ~clk;

  // Galois LFSR that advances one step for each bit taken
  function automatic logic lfsr_bit();
    logic b;
    b = lfsr[0];
    lfsr = (lfsr >> 1) ^ (b ? 16'hB400 : 16'h0000);
    return b;
  endfunction

  // Idle gap of 0 to 3 cycles between commands
  task automatic idle_gap();
    int n;
    n = {lfsr_bit(), lfsr_bit()};
    repeat (n) begin
      @(posedge clk);
      #1;
    end
  endtask

  task automatic report(input string name, input bit ok);
    if (ok) begin
      n_pass++;
      $display("ok    %s", name);
    end else begin
      n_fail++;
      $display("fail  %s", name);
    end
  endtask

  task automatic check_word(input string name, input logic [15:0] exp, input logic [15:0] act,
                            inout bit ok);
    if (exp !== act) begin
      $display("[ERROR] %s: expected %h, actual %h", name, exp, act);
      ok = 1'b0;
    end
  endtask

  // One strobe cycle, then one settle cycle so the engine sees the new value while idle
  task automatic cfg_write(input logic [3:0] addr, input logic [15:0] data);
    cfg_we    = 1'b1;
    cfg_addr  = addr;
    cfg_wdata = data;
    @(posedge clk);
    #1;
    cfg_we = 1'b0;
    @(posedge clk);
    #1;
  endtask

  task automatic check_idle(input string name, input int cycles);
    bit ok;
    ok = 1'b1;
    repeat (cycles) begin
      @(negedge clk);
      check_word(name, 16'h0000, {12'h0, calc_ack, op_ack}, ok);
      @(posedge clk);
      #1;
    end
    report(name, ok);
  endtask

  // Raises the requests of the banks set in banks and collects one ack per bank
  task automatic run_calc(input string name, input logic [1:0] banks,
                          input logic [1:0][9:0] addr, input logic [1:0][15:0] exp);
    logic [1:0] done;
    int         cycles;
    bit         ok;
    ok        = 1'b1;
    done      = '0;
    cycles    = 0;
    calc_addr = addr;
    calc_req  = banks;
    while (done != banks) begin
      @(negedge clk);
      if ((calc_ack & (~banks | done)) != '0 || calc_ack == 2'b11) begin
        $display("%s: calc ack reached a bank that was not waiting for it", name);
        ok = 1'b0;
      end
      for (int b = 0; b < NumBanks; b++) begin
        if (calc_ack[b] && banks[b] && !done[b]) begin
          check_word(name, exp[b], mask, ok);
          done[b] = 1'b1;
        end
      end
      @(posedge clk);
      #1;
      calc_req = banks & ~done;
      cycles++;
      if (cycles >= TimeoutCycles && done != banks) begin
        $display("%s: timed out waiting for calc ack", name);
        ok       = 1'b0;
        calc_req = '0;
        break;
      end
    end
    report(name, ok);
  endtask

  // Same as run_calc for the data path, with an optional config write in flight
  task automatic run_op(input string name, input logic [1:0] banks, input logic [1:0] types,
                        input logic [1:0][15:0] pl, input logic [1:0][15:0] sc,
                        input logic [1:0][15:0] exp_pl, input logic [1:0][15:0] exp_sc,
                        input bit cfg_en, input logic [3:0] c_addr, input logic [15:0] c_data);
    logic [1:0] done;
    int         cycles;
    bit         ok;
    ok       = 1'b1;
    done     = '0;
    cycles   = 0;
    op_type  = types;
    plain_in = pl;
    scr_in   = sc;
    op_req   = banks;
    if (cfg_en) begin
      cfg_we    = 1'b1;
      cfg_addr  = c_addr;
      cfg_wdata = c_data;
    end
    while (done != banks) begin
      @(negedge clk);
      if ((op_ack & (~banks | done)) != '0 || op_ack == 2'b11) begin
        $display("%s: op ack reached a bank that was not waiting for it", name);
        ok = 1'b0;
      end
      for (int b = 0; b < NumBanks; b++) begin
        if (op_ack[b] && banks[b] && !done[b]) begin
          check_word(name, exp_pl[b], plain_out, ok);
          check_word(name, exp_sc[b], scr_out, ok);
          done[b] = 1'b1;
        end
      end
      @(posedge clk);
      #1;
      cfg_we = 1'b0;
      op_req = banks & ~done;
      cycles++;
      if (cycles >= TimeoutCycles && done != banks) begin
        $display("%s: timed out waiting for op ack", name);
        ok     = 1'b0;
        op_req = '0;
        break;
      end
    end
    report(name, ok);
  endtask

  initial begin
    int          fd, code, lineno;
    string       line, name;
    logic [7:0]  cmd;
    logic [15:0] v0, v1, v2, v3, v4, v5, v6, v7, v8, v9;
    clk       = 1'b0;
    rst_n     = 1'b0;
    cfg_we    = 1'b0;
    cfg_addr  = '0;
    cfg_wdata = '0;
    calc_req  = '0;
    calc_addr = '0;
    op_req    = '0;
    op_type   = '0;
    plain_in  = '0;
    scr_in    = '0;
    lfsr      = 16'd48517;
    n_pass    = 0;
    n_fail    = 0;
    lineno    = 0;
    repeat (4) @(posedge clk);
    #1;
    rst_n = 1'b1;
    fd = $fopen("dv/scramble_stim.txt", "r");
    if (fd == 0) begin
      $display("Could not open the stim file dv/scramble_stim.txt");
      n_fail++;
    end else begin
      while (!$feof(fd)) begin
        code = $fgets(line, fd);
        lineno++;
        if (code == 0 || line.len() < 2 || line[0] == "#") begin
          continue;
        end
        code = $sscanf(line, "%c %h %h %h %h %h %h %h %h %h %h", cmd,
                       v0, v1, v2, v3, v4, v5, v6, v7, v8, v9);
        case (cmd)
          "W": cfg_write(v0[3:0], v1);
          "I": check_idle($sformatf("idle_line%0d", lineno), int'(v0));
          "C": begin
            name = $sformatf("calc_line%0d", lineno);
            run_calc(name, 2'b01 << v0[0], {v1[9:0], v1[9:0]}, {v2, v2});
          end
          "D": run_calc($sformatf("dual_calc_line%0d", lineno), 2'b11,
                        {v2[9:0], v0[9:0]}, {v3, v1});
          "O", "X": begin
            name = $sformatf("op_line%0d", lineno);
            run_op(name, 2'b01 << v0[0], {v1[0], v1[0]}, {v2, v2}, {v3, v3}, {v4, v4},
                   {v5, v5}, cmd == "X", v6[3:0], v7);
          end
          "Q": run_op($sformatf("dual_op_line%0d", lineno), 2'b11, {v5[0], v0[0]},
                      {v6, v1}, {v7, v2}, {v8, v3}, {v9, v4}, 1'b0, 4'h0, 16'h0);
          default: begin
            $display("Unknown command on stim line %0d", lineno);
            n_fail++;
          end
        endcase
        idle_gap();
      end
      $fclose(fd);
    end
    $display("Tests passed: %0d, tests failed: %0d", n_pass, n_fail);
    if (n_fail == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== dv/scramble_stim.txt ====
# Hex fields. W cfg_addr data | I cycles | C bank addr mask | D addr0 mask0 addr1 mask1
# O/X bank type plain scr exp_plain exp_scr (X adds cfg_addr data) | Q = O fields bank0, bank1
I a
W 0 0001
W 1 0005
W 2 0000
W 3 0000
W 4 0004
W 5 0021
W 6 ffff
W 7 ffff
C 0 123 1523
C 1 3a5 17a5
O 0 0 0000 1111 1111 4bcc
O 1 1 2222 4bcc 0000 2222
D 123 1523 3a5 17a5
Q 0 0000 1111 1111 4bcc 1 2222 4bcc 0000 2222
W 8 0001
C 0 123 349a
C 1 0ff 33ea
O 0 0 0000 3333 3333 c96a
O 1 1 4444 c96a 0000 4444
W 8 0000
C 1 123 1523
O 0 0 0000 5555 5555 4bcc
X 1 0 0000 6666 6666 4bcc 8 0001
O 0 0 0000 7777 7777 c96a
O 1 1 9999 c96a 0000 9999
W 8 0000
O 1 0 0000 8888 8888 4bcc
C 0 0ff 14ff

// ==== flash_scramble.f ====
hw/flash_scramble_pkg.sv
hw/scramble_key_regs.sv
hw/bank_arbiter.sv
hw/gf_mult_serial.sv
hw/spn_cipher.sv
hw/flash_scramble.sv
hw/flash_scramble_top.sv
dv/flash_scramble_tb.sv

// ==== hw/bank_arbiter.sv ====
/* Round-robin arbiter between the flash banks for one engine service.
   Forwards the winning request and payload and returns ready as that bank's grant. */
`default_nettype none

module bank_arbiter #(
  parameter int DW = 16
) (
  input  logic                                              clk_i,
  input  logic                                              rst_ni,
  input  logic [flash_scramble_pkg::NumBanks-1:0]           req_i,
  input  logic [flash_scramble_pkg::NumBanks-1:0][DW-1:0]   data_i,
  output logic [flash_scramble_pkg::NumBanks-1:0]           gnt_o,
  output logic                                              valid_o,
  output logic [DW-1:0]                                     data_o,
  input  logic                                              ready_i
);
  import flash_scramble_pkg::*;

  // Bank with the highest priority in the current round
  logic [ArbIdxW-1:0] ptr_q;
  // Winner of an open transaction is held until its grant
  logic               lock_q;
  logic [ArbIdxW-1:0] held_q;
  logic [ArbIdxW-1:0] pick;
  logic [ArbIdxW-1:0] winner;

  // Walk from the bank farthest from the pointer to the nearest one, so the
  // nearest requester is the last one written and wins
  always_comb begin
    int unsigned idx;
    pick = ptr_q;
    for (int i = NumBanks - 1; i >= 0; i--) begin
      idx = (int'(ptr_q) + i) % NumBanks;
      if (req_i[idx]) begin
        pick = ArbIdxW'(idx);
      end
    end
  end

  // A new request must not steal the engine from a bank that is already being served
  assign winner  = lock_q ? held_q : pick;
  assign valid_o = req_i[winner];
  assign data_o  = data_i[winner];

  always_comb begin
    gnt_o         = '0;
    gnt_o[winner] = valid_o & ready_i;
  end

  // Priority moves past the winner on each completed transaction
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ptr_q  <= '0;
      held_q <= '0;
      lock_q <= 1'b0;
    end else if (valid_o && ready_i) begin
      ptr_q  <= (int'(winner) == NumBanks - 1) ? '0 : winner + 1'b1;
      lock_q <= 1'b0;
    end else begin
      lock_q <= valid_o;
      held_q <= winner;
    end
  end

endmodule

`default_nettype wire

// ==== hw/flash_scramble.sv ====
/* Scramble engine shared by the flash banks: address masks through the GF multiplier
   and data scrambling through the SPN cipher, each behind its own bank arbiter. */
`default_nettype none

module flash_scramble (
  input  logic                                                  clk_i,
  input  logic                                                  rst_ni,
  input  logic                                                  disable_i,
  input  logic [flash_scramble_pkg::KeySize-1:0]                addr_key_i,
  input  logic [flash_scramble_pkg::KeySize-1:0]                data_key_i,
  input  logic [flash_scramble_pkg::KeySize-1:0]                rand_addr_key_i,
  input  logic [flash_scramble_pkg::KeySize-1:0]                rand_data_key_i,
  input  logic [flash_scramble_pkg::NumBanks-1:0]               calc_req_i,
  input  logic [flash_scramble_pkg::NumBanks-1:0]
               [flash_scramble_pkg::BankAddrW-1:0]              calc_addr_i,
  output logic [flash_scramble_pkg::NumBanks-1:0]               calc_ack_o,
  output logic [flash_scramble_pkg::DataWidth-1:0]              mask_o,
  input  logic [flash_scramble_pkg::NumBanks-1:0]               op_req_i,
  input  logic [flash_scramble_pkg::NumBanks-1:0]               op_type_i,
  input  logic [flash_scramble_pkg::NumBanks-1:0]
               [flash_scramble_pkg::DataWidth-1:0]              plain_data_i,
  input  logic [flash_scramble_pkg::NumBanks-1:0]
               [flash_scramble_pkg::DataWidth-1:0]              scrambled_data_i,
  output logic [flash_scramble_pkg::NumBanks-1:0]               op_ack_o,
  output logic [flash_scramble_pkg::DataWidth-1:0]              plain_data_o,
  output logic [flash_scramble_pkg::DataWidth-1:0]              scrambled_data_o
);
  import flash_scramble_pkg::*;

  //////////////////////////////////////////////////
  // Bank arbitration
  //////////////////////////////////////////////////

  logic                                  calc_req, calc_ack, op_req, op_ack;
  logic [BankAddrW-1:0]                  calc_addr;
  logic [NumBanks-1:0][OpDataWidth-1:0]  op_data_banks;
  logic [OpDataWidth-1:0]                op_data;
  cipher_op_e                            op_type;
  logic [DataWidth-1:0]                  plain_in, scrambled_in;

  for (genvar k = 0; k < NumBanks; k++) begin : gen_op_pack
    assign op_data_banks[k] = {op_type_i[k], plain_data_i[k], scrambled_data_i[k]};
  end

  bank_arbiter #(.DW(BankAddrW)) u_arb_calc (
    .clk_i,
    .rst_ni,
    .req_i   (calc_req_i),
    .data_i  (calc_addr_i),
    .gnt_o   (calc_ack_o),
    .valid_o (calc_req),
    .data_o  (calc_addr),
    .ready_i (calc_ack)
  );

  bank_arbiter #(.DW(OpDataWidth)) u_arb_op (
    .clk_i,
    .rst_ni,
    .req_i   (op_req_i),
    .data_i  (op_data_banks),
    .gnt_o   (op_ack_o),
    .valid_o (op_req),
    .data_o  (op_data),
    .ready_i (op_ack)
  );

  assign op_type      = cipher_op_e'(op_data[OpDataWidth-1]);
  assign plain_in     = op_data[DataWidth +: DataWidth];
  assign scrambled_in = op_data[0 +: DataWidth];

  //////////////////////////////////////////////////
  // Address mask
  //////////////////////////////////////////////////

  // Key choice follows disable only between transactions, never inside one
  logic                 addr_key_sel;
  logic [KeySize-1:0]   addr_key;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      addr_key_sel <= 1'b0;
    end else if (!calc_req || calc_ack) begin
      addr_key_sel <= disable_i;
    end
  end

  assign addr_key = addr_key_sel ? rand_addr_key_i : addr_key_i;

  // The upper key bits pad the bank address out to a full field element
  gf_mult_serial u_mult (
    .clk_i,
    .rst_ni,
    .req_i       (calc_req),
    .operand_a_i ({addr_key[DataWidth +: AddrPadWidth], calc_addr}),
    .operand_b_i (addr_key[DataWidth-1:0]),
    .ack_o       (calc_ack),
    .prod_o      (mask_o)
  );

  //////////////////////////////////////////////////
  // Data cipher
  //////////////////////////////////////////////////

  logic                 dec;
  logic                 data_key_sel;
  logic                 cipher_valid_in_d, cipher_valid_in_q, cipher_valid_out;
  logic [DataWidth-1:0] cipher_data;

  assign dec = (op_type == DeScrambleOp);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      data_key_sel <= 1'b0;
    end else if (!op_req || op_ack) begin
      data_key_sel <= disable_i;
    end
  end

  // The cipher output valid alone could be a stale word from a held request,
  // so the ack also needs the registered input valid, which drops on each ack
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cipher_valid_in_q <= 1'b0;
    end else begin
      cipher_valid_in_q <= cipher_valid_in_d;
    end
  end

  // No new word enters while a result is still in the output stage
  assign cipher_valid_in_d = op_ack ? 1'b0 : op_req & ~cipher_valid_out;
  assign op_ack            = cipher_valid_in_q & cipher_valid_out;

  spn_cipher u_cipher (
    .clk_i,
    .rst_ni,
    .valid_i (cipher_valid_in_d),
    .data_i  (dec ? scrambled_in : plain_in),
    .key_i   (data_key_sel ? rand_data_key_i : data_key_i),
    .dec_i   (dec),
    .data_o  (cipher_data),
    .valid_o (cipher_valid_out)
  );

  // The side that is not computed echoes the other input word
  assign plain_data_o     = dec ? cipher_data : scrambled_in;
  assign scrambled_data_o = dec ? plain_in : cipher_data;

endmodule

`default_nettype wire

// ==== hw/flash_scramble_pkg.sv ====
/* Shared constants and types of the flash scramble engine.
   Every RTL file imports this package by wildcard inside its body. */
`default_nettype none

package flash_scramble_pkg;

  //////////////////////////////////////////////////
  // Sizes
  //////////////////////////////////////////////////

  localparam int NumBanks     = 2;
  localparam int ArbIdxW      = $clog2(NumBanks);
  localparam int DataWidth    = 16;
  localparam int BankAddrW    = 10;
  localparam int KeySize      = 32;
  // Address key bits that fill the multiplier operand above the bank address
  localparam int AddrPadWidth = 6;

  //////////////////////////////////////////////////
  // GF(2^16) multiplier
  //////////////////////////////////////////////////

  localparam int GfMultCycles     = 4;
  localparam int GfStagesPerCycle = DataWidth / GfMultCycles;
  localparam int GfCntW           = $clog2(GfMultCycles);
  // x^16 + x^12 + x^3 + x + 1 with the leading term dropped
  localparam logic [DataWidth-1:0] ScrambleIPoly = 16'h100B;

  //////////////////////////////////////////////////
  // SPN cipher
  //////////////////////////////////////////////////

  localparam int NumRounds = 4;
  // Each round key comes from the data key rotated left by this many bits per round
  localparam int KeyRotate = 8;
  // PRESENT S-box, entry n sits at bits [4n +: 4]
  localparam logic [15:0][3:0] SBOX     = 64'h21748FE3DA09B65C;
  localparam logic [15:0][3:0] SBOX_INV = 64'hA970364BD21C8FE5;

  //////////////////////////////////////////////////
  // Configuration register map
  //////////////////////////////////////////////////

  localparam int CfgAddrW = 4;
  localparam logic [CfgAddrW-1:0] CfgAddrKeyLo     = 4'd0;
  localparam logic [CfgAddrW-1:0] CfgAddrKeyHi     = 4'd1;
  localparam logic [CfgAddrW-1:0] CfgDataKeyLo     = 4'd2;
  localparam logic [CfgAddrW-1:0] CfgDataKeyHi     = 4'd3;
  localparam logic [CfgAddrW-1:0] CfgRandAddrKeyLo = 4'd4;
  localparam logic [CfgAddrW-1:0] CfgRandAddrKeyHi = 4'd5;
  localparam logic [CfgAddrW-1:0] CfgRandDataKeyLo = 4'd6;
  localparam logic [CfgAddrW-1:0] CfgRandDataKeyHi = 4'd7;
  localparam logic [CfgAddrW-1:0] CfgDisable       = 4'd8;

  // Operation requested by a bank
  typedef enum logic {
    ScrambleOp   = 1'b0,
    DeScrambleOp = 1'b1
  } cipher_op_e;

  // Per-bank operation payload is {op_type, plain_data, scrambled_data}
  localparam int OpDataWidth = 2 * DataWidth + $bits(cipher_op_e);

endpackage

`default_nettype wire

// ==== hw/flash_scramble_top.sv ====
/* Top level of the scramble block: configuration key registers feeding the engine.
   Banks connect to the request ports, software writes keys through the config strobe. */
`default_nettype none

module flash_scramble_top (
  input  logic                                                  clk_i,
  input  logic                                                  rst_ni,
  input  logic                                                  cfg_we_i,
  input  logic [flash_scramble_pkg::CfgAddrW-1:0]               cfg_addr_i,
  input  logic [flash_scramble_pkg::DataWidth-1:0]              cfg_wdata_i,
  input  logic [flash_scramble_pkg::NumBanks-1:0]               calc_req_i,
  input  logic [flash_scramble_pkg::NumBanks-1:0]
               [flash_scramble_pkg::BankAddrW-1:0]              calc_addr_i,
  output logic [flash_scramble_pkg::NumBanks-1:0]               calc_ack_o,
  output logic [flash_scramble_pkg::DataWidth-1:0]              mask_o,
  input  logic [flash_scramble_pkg::NumBanks-1:0]               op_req_i,
  input  logic [flash_scramble_pkg::NumBanks-1:0]               op_type_i,
  input  logic [flash_scramble_pkg::NumBanks-1:0]
               [flash_scramble_pkg::DataWidth-1:0]              plain_data_i,
  input  logic [flash_scramble_pkg::NumBanks-1:0]
               [flash_scramble_pkg::DataWidth-1:0]              scrambled_data_i,
  output logic [flash_scramble_pkg::NumBanks-1:0]               op_ack_o,
  output logic [flash_scramble_pkg::DataWidth-1:0]              plain_data_o,
  output logic [flash_scramble_pkg::DataWidth-1:0]              scrambled_data_o
);
  import flash_scramble_pkg::*;

  logic [KeySize-1:0] addr_key, data_key, rand_addr_key, rand_data_key;
  logic               scramble_disable;

  scramble_key_regs u_key_regs (
    .clk_i,
    .rst_ni,
    .cfg_we_i,
    .cfg_addr_i,
    .cfg_wdata_i,
    .addr_key_o      (addr_key),
    .data_key_o      (data_key),
    .rand_addr_key_o (rand_addr_key),
    .rand_data_key_o (rand_data_key),
    .disable_o       (scramble_disable)
  );

  flash_scramble u_scramble (
    .clk_i,
    .rst_ni,
    .disable_i       (scramble_disable),
    .addr_key_i      (addr_key),
    .data_key_i      (data_key),
    .rand_addr_key_i (rand_addr_key),
    .rand_data_key_i (rand_data_key),
    .calc_req_i,
    .calc_addr_i,
    .calc_ack_o,
    .mask_o,
    .op_req_i,
    .op_type_i,
    .plain_data_i,
    .scrambled_data_i,
    .op_ack_o,
    .plain_data_o,
    .scrambled_data_o
  );

endmodule

`default_nettype wire

// ==== hw/gf_mult_serial.sv ====
/* Serial GF(2^16) multiplier for the address mask.
   Takes GfMultCycles cycles of work, then pulses ack_o with the product held. */
`default_nettype none

module gf_mult_serial (
  input  logic                                     clk_i,
  input  logic                                     rst_ni,
  input  logic                                     req_i,
  input  logic [flash_scramble_pkg::DataWidth-1:0] operand_a_i,
  input  logic [flash_scramble_pkg::DataWidth-1:0] operand_b_i,
  output logic                                     ack_o,
  output logic [flash_scramble_pkg::DataWidth-1:0] prod_o
);
  import flash_scramble_pkg::*;

  logic                        busy_q;
  logic                        ack_q;
  logic [GfCntW-1:0]           cnt_q;
  logic [DataWidth-1:0]        acc_q;
  logic [DataWidth-1:0]        acc_d;
  logic [GfStagesPerCycle-1:0] b_chunk;

  // Operand b is consumed MSB first, one chunk per cycle
  // The requester holds both operands steady until the ack
  assign b_chunk = operand_b_i[DataWidth - 1 - int'(cnt_q) * GfStagesPerCycle -: GfStagesPerCycle];

  // Horner steps: multiply the accumulator by x, reduce, then add a if the bit is set
  always_comb begin
    acc_d = busy_q ? acc_q : '0;
    for (int j = GfStagesPerCycle - 1; j >= 0; j--) begin
      acc_d = {acc_d[DataWidth-2:0], 1'b0} ^ (acc_d[DataWidth-1] ? ScrambleIPoly : '0);
      if (b_chunk[j]) begin
        acc_d = acc_d ^ operand_a_i;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q <= 1'b0;
      ack_q  <= 1'b0;
      cnt_q  <= '0;
    end else if (ack_q) begin
      // The ack cycle never starts a new multiply, the request is sampled again after it
      ack_q <= 1'b0;
    end else if (busy_q || req_i) begin
      if (int'(cnt_q) == GfMultCycles - 1) begin
        busy_q <= 1'b0;
        ack_q  <= 1'b1;
        cnt_q  <= '0;
      end else begin
        busy_q <= 1'b1;
        cnt_q  <= cnt_q + 1'b1;
      end
    end
  end

  // The accumulator doubles as the product register
  always_ff @(posedge clk_i) begin
    if (!ack_q && (busy_q || req_i)) begin
      acc_q <= acc_d;
    end
  end

  assign ack_o  = ack_q;
  assign prod_o = acc_q;

endmodule

`default_nettype wire

// ==== hw/scramble_key_regs.sv ====
/* Key and disable registers beside the scramble engine.
   A single-cycle configuration strobe writes one 16-bit key half or the disable bit. */
`default_nettype none

module scramble_key_regs (
  input  logic                                     clk_i,
  input  logic                                     rst_ni,
  input  logic                                     cfg_we_i,
  input  logic [flash_scramble_pkg::CfgAddrW-1:0]  cfg_addr_i,
  input  logic [flash_scramble_pkg::DataWidth-1:0] cfg_wdata_i,
  output logic [flash_scramble_pkg::KeySize-1:0]   addr_key_o,
  output logic [flash_scramble_pkg::KeySize-1:0]   data_key_o,
  output logic [flash_scramble_pkg::KeySize-1:0]   rand_addr_key_o,
  output logic [flash_scramble_pkg::KeySize-1:0]   rand_data_key_o,
  output logic                                     disable_o
);
  import flash_scramble_pkg::*;

  // The outputs are the registers themselves, so a write shows up in the
  // cycle right after the strobe
  // Unmapped addresses fall through to the default branch and change nothing
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      addr_key_o      <= '0;
      data_key_o      <= '0;
      rand_addr_key_o <= '0;
      rand_data_key_o <= '0;
      disable_o       <= 1'b0;
    end else if (cfg_we_i) begin
      case (cfg_addr_i)
        CfgAddrKeyLo:     addr_key_o[0 +: DataWidth]              <= cfg_wdata_i;
        CfgAddrKeyHi:     addr_key_o[DataWidth +: DataWidth]      <= cfg_wdata_i;
        CfgDataKeyLo:     data_key_o[0 +: DataWidth]              <= cfg_wdata_i;
        CfgDataKeyHi:     data_key_o[DataWidth +: DataWidth]      <= cfg_wdata_i;
        CfgRandAddrKeyLo: rand_addr_key_o[0 +: DataWidth]         <= cfg_wdata_i;
        CfgRandAddrKeyHi: rand_addr_key_o[DataWidth +: DataWidth] <= cfg_wdata_i;
        CfgRandDataKeyLo: rand_data_key_o[0 +: DataWidth]         <= cfg_wdata_i;
        CfgRandDataKeyHi: rand_data_key_o[DataWidth +: DataWidth] <= cfg_wdata_i;
        // Only bit 0 of the write data carries the disable flag
        CfgDisable:       disable_o                               <= cfg_wdata_i[0];
        default: begin
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== hw/spn_cipher.sv ====
/* Keyed 16-bit substitution-permutation cipher used to scramble flash data.
   Two pipeline stages of two rounds each; dec_i selects the inverse direction. */
`default_nettype none

module spn_cipher (
  input  logic                                     clk_i,
  input  logic                                     rst_ni,
  input  logic                                     valid_i,
  input  logic [flash_scramble_pkg::DataWidth-1:0] data_i,
  input  logic [flash_scramble_pkg::KeySize-1:0]   key_i,
  input  logic                                     dec_i,
  output logic [flash_scramble_pkg::DataWidth-1:0] data_o,
  output logic                                     valid_o
);
  import flash_scramble_pkg::*;

  //////////////////////////////////////////////////
  // Round primitives
  //////////////////////////////////////////////////

  // Round key r is the low half of the key rotated left by r*KeyRotate bits
  function automatic logic [DataWidth-1:0] round_key(input logic [KeySize-1:0] key,
                                                     input int r);
    logic [2*KeySize-1:0] kk;
    kk = {key, key};
    return kk[KeySize + DataWidth - 1 - KeyRotate * r -: DataWidth];
  endfunction

  function automatic logic [DataWidth-1:0] sbox_layer(input logic [DataWidth-1:0] s,
                                                      input logic inv);
    logic [DataWidth-1:0] y;
    for (int n = 0; n < DataWidth / 4; n++) begin
      y[4*n +: 4] = inv ? SBOX_INV[s[4*n +: 4]] : SBOX[s[4*n +: 4]];
    end
    return y;
  endfunction

  // Bit i moves to 4i mod 15, the top bit stays where it is
  function automatic logic [DataWidth-1:0] perm_layer(input logic [DataWidth-1:0] s,
                                                      input logic inv);
    logic [DataWidth-1:0] y;
    y[DataWidth-1] = s[DataWidth-1];
    for (int i = 0; i < DataWidth - 1; i++) begin
      if (inv) begin
        y[i] = s[(4 * i) % (DataWidth - 1)];
      end else begin
        y[(4 * i) % (DataWidth - 1)] = s[i];
      end
    end
    return y;
  endfunction

  // Forward round is key add, S-box, permute; the inverse undoes them in reverse
  function automatic logic [DataWidth-1:0] do_round(input logic [DataWidth-1:0] s,
                                                    input logic [DataWidth-1:0] k,
                                                    input logic inv);
    if (inv) begin
      return sbox_layer(perm_layer(s, 1'b1), 1'b1) ^ k;
    end
    return perm_layer(sbox_layer(s ^ k, 1'b0), 1'b0);
  endfunction

  //////////////////////////////////////////////////
  // Pipeline
  //////////////////////////////////////////////////

  logic [DataWidth-1:0] stage1_d, stage2_d, mid_q;
  logic                 mid_valid_q;

  // Encrypt runs rounds 0 and 1 here; decrypt strips the final key and undoes rounds 3 and 2
  always_comb begin
    stage1_d = dec_i ? data_i ^ round_key(key_i, NumRounds) : data_i;
    for (int r = 0; r < NumRounds / 2; r++) begin
      stage1_d = dec_i ? do_round(stage1_d, round_key(key_i, NumRounds - 1 - r), 1'b1)
                       : do_round(stage1_d, round_key(key_i, r), 1'b0);
    end
  end

  // Second half finishes the remaining rounds, and encrypt adds the final key
  always_comb begin
    stage2_d = mid_q;
    for (int r = 0; r < NumRounds / 2; r++) begin
      stage2_d = dec_i ? do_round(stage2_d, round_key(key_i, NumRounds / 2 - 1 - r), 1'b1)
                       : do_round(stage2_d, round_key(key_i, NumRounds / 2 + r), 1'b0);
    end
    if (!dec_i) begin
      stage2_d = stage2_d ^ round_key(key_i, NumRounds);
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mid_valid_q <= 1'b0;
      valid_o     <= 1'b0;
    end else begin
      mid_valid_q <= valid_i;
      valid_o     <= mid_valid_q;
    end
  end

  always_ff @(posedge clk_i) begin
    if (valid_i) begin
      mid_q <= stage1_d;
    end
    if (mid_valid_q) begin
      data_o <= stage2_d;
    end
  end

endmodule

`default_nettype wire
